//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = zx_ula_tb
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir

//--- list.f
source/ula_pkg.sv
source/ula_if.sv
source/raster_timing.sv
source/screen_pixels.sv
source/io_ports.sv
source/memory_controller.sv
source/zx_ula.sv
testbench/zx_ula_tb.sv

//--- source/io_ports.sv
`timescale 1ns/10ps
`default_nettype none

module io_ports import ula_pkg::*; (
	input  logic       clk14,
	input  logic       rst_n,
	cpu_bus_if.io      bus,
	input  logic [4:0] kd,
	input  logic       tape_in,
	output colour_t    border,
	output logic       beeper,
	output logic       tape_out,
	output bank_t      ram_bank,
	output logic       screen_shadow,
	output logic       rom_page,
	output logic       port_rd,
	output byte_t      port_data
);

	logic io_cycle;
	logic fe_cs, p7ffd_cs;
	logic fe_wr, p7ffd_wr;
	logic lock;

	assign io_cycle = !bus.iorq_n && bus.m1_n;   // skip interrupt ack
	assign fe_cs = io_cycle && !bus.a[0];
	assign p7ffd_cs = io_cycle && !bus.a[1] && !bus.a[15];
	assign fe_wr = fe_cs && !bus.wr_n;
	assign p7ffd_wr = p7ffd_cs && !bus.wr_n;

	assign port_data = {1'b1, tape_in, 1'b1, kd};

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			port_rd <= 1'b0;
		else
			port_rd <= fe_cs && !bus.rd_n;
	end

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			border <= '0;
			tape_out <= 1'b0;
			beeper <= 1'b0;
		end
		else if (fe_wr) begin
			border <= bus.d_in[2:0];
			tape_out <= bus.d_in[3];
			beeper <= bus.d_in[4];
		end
	end

	// 128k paging, frozen once locked
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			ram_bank <= '0;
			screen_shadow <= 1'b0;
			rom_page <= 1'b0;
			lock <= 1'b0;
		end
		else if (p7ffd_wr && !lock) begin
			ram_bank <= bus.d_in[2:0];
			screen_shadow <= bus.d_in[3];
			rom_page <= bus.d_in[4];
			lock <= bus.d_in[5];
		end
	end

	assert property (@(posedge clk14) disable iff (!rst_n)
		(p7ffd_wr && lock) |=> $stable({ram_bank, screen_shadow, rom_page, lock}))
		else $error("7ffd write changed paging while locked");

endmodule

`default_nettype wire

//--- source/memory_controller.sv
`timescale 1ns/10ps
`default_nettype none

module memory_controller import ula_pkg::*; (
	input  logic       clk14,
	input  logic       rst_n,
	cpu_bus_if.mem     bus,
	screen_fetch_if.mem fetch,
	input  bank_t      ram_bank,
	input  logic       screen_shadow,
	input  logic       port_rd,
	input  byte_t      port_data,
	output vram_addr_t vram_a,
	input  byte_t      vram_d_in,
	output logic       vram_rd_n,
	output logic       vram_wr_n,
	output logic       rom_cs_n,
	output byte_t      cpu_d_out,
	output logic       cpu_d_oe
);

	logic       cpu_idle;
	logic       mem_cycle, rom_area;
	logic       grant;
	logic       cpu_rd_n, cpu_wr_n;
	bank_t      cpu_bank, screen_bank;
	vram_addr_t cpu_vram_a;

	// refresh cycles leave the ram free for the screen
	assign cpu_idle = (bus.mreq_n || !bus.rfsh_n) && bus.iorq_n && bus.m1_n;
	assign mem_cycle = !bus.mreq_n && bus.rfsh_n;
	assign rom_area = bus.a[15:14] == 2'b00;

	always_comb begin
		case (bus.a[15:14])
			2'b01:   cpu_bank = BANK_4000;
			2'b10:   cpu_bank = BANK_8000;
			default: cpu_bank = ram_bank;
		endcase
	end

	assign screen_bank = screen_shadow ? SCREEN_BANK_SHADOW : SCREEN_BANK_NORMAL;

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			grant <= 1'b0;
			rom_cs_n <= 1'b1;
			cpu_rd_n <= 1'b1;
			cpu_wr_n <= 1'b1;
		end
		else begin
			grant <= fetch.active && cpu_idle;
			rom_cs_n <= !(mem_cycle && rom_area);
			cpu_rd_n <= !(mem_cycle && !rom_area && !bus.rd_n);
			cpu_wr_n <= !(mem_cycle && !rom_area && !bus.wr_n);
		end
	end

	always_ff @(posedge clk14)
		cpu_vram_a <= {2'b11, cpu_bank, bus.a[13:0]};

	assign fetch.grant = grant;
	assign fetch.data = vram_d_in;

	assign vram_a = grant ? {2'b11, screen_bank, fetch.addr[13:0]} : cpu_vram_a;
	assign vram_rd_n = cpu_rd_n && !grant;
	assign vram_wr_n = cpu_wr_n || grant;

	// only port FE drives the cpu data bus
	assign cpu_d_out = port_data;
	assign cpu_d_oe = port_rd;

	assert property (@(posedge clk14) disable iff (!rst_n) !(!vram_rd_n && !vram_wr_n))
		else $error("video ram read and write strobes overlap");

endmodule

`default_nettype wire

//--- source/raster_timing.sv
`timescale 1ns/10ps
`default_nettype none

module raster_timing import ula_pkg::*; (
	input  logic     clk14,
	input  logic     rst_n,
	output hcount2_t hc2,
	output vcount_t  vc,
	output logic     blank,
	output logic     hsync,
	output logic     vsync,
	output logic     csync,
	output logic     int_n,
	output logic     cpu_clk
);

	localparam hcount2_t HC2_LAST = hcount2_t'(2 * H_TOTAL - 1);
	localparam vcount_t  VC_LAST  = V_TOTAL - 9'd1;

	hcount_t hc;
	logic    hsync0, vsync0, int0;

	assign hc = hc2[9:1];

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hc2 <= '0;
			vc <= '0;
		end
		else if (hc2 == HC2_LAST) begin
			hc2 <= '0;
			vc <= (vc == VC_LAST) ? '0 : vc + 9'd1;
		end
		else begin
			hc2 <= hc2 + 10'd1;
		end
	end

	assign hsync0 = (hc >= H_SYNC_START) && (hc < H_SYNC_START + H_SYNC_LEN);
	assign vsync0 = (vc >= V_SYNC_START) && (vc < V_SYNC_START + V_SYNC_LEN);
	assign int0 = (vc == INT_LINE) && (hc >= INT_H_FROM) && (hc < INT_H_TO);
	assign blank = vsync0 || ((hc >= H_BLANK_START) && (hc < H_BLANK_END));

	// sampled once per pixel
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			csync <= 1'b0;
			int_n <= 1'b1;
		end
		else if (hc2[0]) begin
			hsync <= hsync0;
			vsync <= vsync0;
			csync <= ~(hsync0 ^ vsync0);
			int_n <= ~int0;
		end
	end

	always_ff @(negedge clk14 or negedge rst_n) begin
		if (!rst_n)
			cpu_clk <= 1'b0;
		else
			cpu_clk <= hc2[1];   // clk14 / 4
	end

	assert property (@(posedge clk14) disable iff (!rst_n) (hc2 <= HC2_LAST) && (vc <= VC_LAST))
		else $error("raster counter out of range");

endmodule

`default_nettype wire

//--- source/screen_pixels.sv
`timescale 1ns/10ps
`default_nettype none

module screen_pixels import ula_pkg::*; (
	input  logic     clk14,
	input  logic     rst_n,
	input  hcount2_t hc2,
	input  vcount_t  vc,
	input  logic     blank,
	input  colour_t  border,
	screen_fetch_if.pixels fetch,
	output logic     r,
	output logic     g,
	output logic     b,
	output logic     i
);

	hcount_t      hc;
	logic         ck7;
	logic         in_rows;
	logic         show;
	logic         load;
	logic         pixel;
	screen_addr_t bitmap_addr;
	screen_addr_t attr_addr;
	byte_t        bitmap, attr;
	byte_t        bitmap_next, attr_next;
	colour_t      ink, paper, colour;

	assign hc = hc2[9:1];
	assign ck7 = hc2[0];   // second clk14 of a pixel
	assign in_rows = vc < V_AREA;

	// interleaved spectrum layout, attributes at 0x1800
	assign bitmap_addr = {2'b00, vc[7:6], vc[2:0], vc[5:3], hc[7:3]};
	assign attr_addr = {5'b00110, vc[7:3], hc[7:3]};

	assign fetch.active = in_rows && (hc < H_AREA);
	assign fetch.addr = ck7 ? bitmap_addr : attr_addr;

	// new character cell every eight pixels
	assign load = in_rows && (hc < H_AREA) && (hc[2:0] == 3'd7) && !ck7;
	assign show = in_rows && (hc >= SCREEN_DELAY) && (hc < H_AREA + SCREEN_DELAY);

	assign pixel = show && bitmap[7];
	assign ink = attr[2:0];
	assign paper = show ? attr[5:3] : border;   // border is paper with no pixels
	assign colour = pixel ? ink : paper;

	always_ff @(posedge clk14) begin
		if (fetch.grant && !ck7)
			attr_next <= fetch.data;
		if (fetch.grant && ck7)
			bitmap_next <= fetch.data;

		if (load) begin
			attr <= attr_next;
			bitmap <= bitmap_next;
		end
		else if (!ck7) begin
			bitmap <= {bitmap[6:0], 1'b0};
		end
	end

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			{i, g, r, b} <= 4'b0000;
		end
		else if (!ck7) begin
			if (blank) begin
				{i, g, r, b} <= 4'b0000;
			end
			else begin
				{g, r, b} <= colour;
				i <= show && attr[6] && (colour != 3'b000);   // no bright black
			end
		end
	end

endmodule

`default_nettype wire

//--- source/ula_if.sv
`timescale 1ns/10ps
`default_nettype none

interface cpu_bus_if import ula_pkg::*; ();
	logic [15:0] a;
	byte_t       d_in;
	logic        rd_n;
	logic        wr_n;
	logic        mreq_n;
	logic        iorq_n;
	logic        m1_n;
	logic        rfsh_n;

	modport io (input a, d_in, rd_n, wr_n, iorq_n, m1_n);
	modport mem (input a, rd_n, wr_n, mreq_n, iorq_n, m1_n, rfsh_n);
endinterface

// screen fetch, the cpu always wins the video ram
interface screen_fetch_if import ula_pkg::*; ();
	logic         active;
	screen_addr_t addr;   // attr on first clk14, bitmap on second
	logic         grant;
	byte_t        data;

	modport pixels (output active, addr, input grant, data);
	modport mem (input active, addr, output grant, data);
endinterface

`default_nettype wire

//--- source/ula_pkg.sv
`default_nettype none

package ula_pkg;

	typedef logic [8:0]  hcount_t;   // pixel column
	typedef logic [9:0]  hcount2_t;  // half-pixel count
	typedef logic [8:0]  vcount_t;   // line number
	typedef logic [7:0]  byte_t;
	typedef logic [2:0]  colour_t;   // g, r, b
	typedef logic [2:0]  bank_t;
	typedef logic [14:0] screen_addr_t;
	typedef logic [18:0] vram_addr_t;

	localparam hcount_t H_AREA       = 9'd256;
	localparam vcount_t V_AREA       = 9'd192;
	localparam hcount_t SCREEN_DELAY = 9'd8;

	// pentagon raster
	localparam hcount_t H_TOTAL       = 9'd448;
	localparam vcount_t V_TOTAL       = 9'd320;
	localparam hcount_t H_BLANK_START = 9'd320;
	localparam hcount_t H_BLANK_END   = 9'd392;
	localparam hcount_t H_SYNC_START  = 9'd328;
	localparam hcount_t H_SYNC_LEN    = 9'd33;
	localparam vcount_t V_SYNC_START  = 9'd248;
	localparam vcount_t V_SYNC_LEN    = 9'd8;

	localparam vcount_t INT_LINE   = 9'd239;
	localparam hcount_t INT_H_FROM = 9'd316;
	localparam hcount_t INT_H_TO   = 9'd384;

	localparam bank_t SCREEN_BANK_NORMAL = 3'd5;
	localparam bank_t SCREEN_BANK_SHADOW = 3'd7;
	localparam bank_t BANK_4000          = 3'd5;
	localparam bank_t BANK_8000          = 3'd2;

endpackage

`default_nettype wire

//--- source/zx_ula.sv
`timescale 1ns/10ps
`default_nettype none

module zx_ula import ula_pkg::*; (
	input  logic        clk14,
	input  logic        rst_n,

	input  logic [15:0] cpu_a,
	input  byte_t       cpu_d_in,
	output byte_t       cpu_d_out,
	output logic        cpu_d_oe,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        m1_n,
	input  logic        rfsh_n,

	output logic        int_n,
	output logic        cpu_clk,

	input  logic [4:0]  kd,
	input  logic        tape_in,
	output logic        tape_out,
	output logic        beeper,

	output logic        r,
	output logic        g,
	output logic        b,
	output logic        i,
	output logic        hsync,
	output logic        vsync,
	output logic        csync,

	output vram_addr_t  vram_a,
	input  byte_t       vram_d_in,
	output logic        vram_rd_n,
	output logic        vram_wr_n,
	output logic        rom_cs_n,
	output logic        rom_page
);

	hcount2_t hc2;
	vcount_t  vc;
	logic     blank;
	colour_t  border;
	bank_t    ram_bank;
	logic     screen_shadow;
	logic     port_rd;
	byte_t    port_data;

	cpu_bus_if bus ();
	screen_fetch_if fetch ();

	assign bus.a = cpu_a;
	assign bus.d_in = cpu_d_in;
	assign bus.rd_n = rd_n;
	assign bus.wr_n = wr_n;
	assign bus.mreq_n = mreq_n;
	assign bus.iorq_n = iorq_n;
	assign bus.m1_n = m1_n;
	assign bus.rfsh_n = rfsh_n;

	raster_timing raster_timing_i (
		.clk14(clk14), .rst_n(rst_n), .hc2(hc2), .vc(vc), .blank(blank),
		.hsync(hsync), .vsync(vsync), .csync(csync), .int_n(int_n), .cpu_clk(cpu_clk)
	);

	screen_pixels screen_pixels_i (
		.clk14(clk14), .rst_n(rst_n), .hc2(hc2), .vc(vc), .blank(blank),
		.border(border), .fetch(fetch), .r(r), .g(g), .b(b), .i(i)
	);

	io_ports io_ports_i (
		.clk14(clk14), .rst_n(rst_n), .bus(bus), .kd(kd), .tape_in(tape_in),
		.border(border), .beeper(beeper), .tape_out(tape_out), .ram_bank(ram_bank),
		.screen_shadow(screen_shadow), .rom_page(rom_page), .port_rd(port_rd),
		.port_data(port_data)
	);

	memory_controller memory_controller_i (
		.clk14(clk14), .rst_n(rst_n), .bus(bus), .fetch(fetch), .ram_bank(ram_bank),
		.screen_shadow(screen_shadow), .port_rd(port_rd), .port_data(port_data),
		.vram_a(vram_a), .vram_d_in(vram_d_in), .vram_rd_n(vram_rd_n),
		.vram_wr_n(vram_wr_n), .rom_cs_n(rom_cs_n), .cpu_d_out(cpu_d_out),
		.cpu_d_oe(cpu_d_oe)
	);

endmodule

`default_nettype wire

//--- testbench/zx_ula_tb.sv
`timescale 1ns/10ps
`default_nettype none

module zx_ula_tb;

	localparam int CLK_NS = 10;
	localparam int LINE_CYCLES = 896;   // 448 pixels, two clk14 each
	localparam int FRAME_CYCLES = LINE_CYCLES * 320;
	localparam int SCREEN_DELAY = 8;

	localparam int OP_FE_WR = 0;
	localparam int OP_FE_RD = 1;
	localparam int OP_7FFD_WR = 2;
	localparam int OP_MEM_RD = 3;
	localparam int OP_PROBE = 4;
	localparam int OP_MEM_WR = 5;

	logic        clk14 = 1'b0;
	logic        rst_n;
	logic [15:0] cpu_a;
	logic [7:0]  cpu_d_in, cpu_d_out;
	logic        cpu_d_oe;
	logic        rd_n, wr_n, mreq_n, iorq_n, m1_n, rfsh_n;
	logic        int_n, cpu_clk;
	logic [4:0]  kd;
	logic        tape_in, tape_out, beeper;
	logic        r, g, b, i, hsync, vsync, csync;
	logic [18:0] vram_a;
	logic [7:0]  vram_d_in;
	logic        vram_rd_n, vram_wr_n, rom_cs_n, rom_page;

	int   errors = 0;
	int   checks = 0;
	int   hc2_now, line_now;   // raster position seen by the tb
	logic table_ready = 1'b0;

	// stimulus table, one column per queue
	string t_name[$];
	int    t_op[$], t_addr[$], t_data[$], t_line[$], t_slot[$], t_exp[$];

	zx_ula zx_ula_i (.*);

	always #(CLK_NS / 2) clk14 = ~clk14;

	always @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hc2_now <= 0;
			line_now <= 0;
		end
		else if (hc2_now == LINE_CYCLES - 1) begin
			hc2_now <= 0;
			line_now <= (line_now == 319) ? 0 : line_now + 1;
		end
		else begin
			hc2_now <= hc2_now + 1;
		end
	end

	// video ram contents, low address byte xor the next one
	function automatic logic [7:0] vram_model(input logic [18:0] addr);
		return addr[7:0] ^ addr[15:8];
	endfunction

	assign vram_d_in = vram_model(vram_a);

	function automatic logic [3:0] expected_pixel(input int bank, input int x, input int y);
		int         bitmap_off, attr_off;
		logic [7:0] bits, attr;
		logic [2:0] colour;
		bitmap_off = (y / 64) * 2048 + (y % 8) * 256 + ((y / 8) % 8) * 32 + x / 8;
		attr_off = 'h1800 + (y / 8) * 32 + x / 8;
		bits = vram_model({2'b11, bank[2:0], bitmap_off[13:0]});
		attr = vram_model({2'b11, bank[2:0], attr_off[13:0]});
		bits = bits << (x % 8);   // msb is leftmost pixel
		colour = bits[7] ? attr[2:0] : attr[5:3];
		return {attr[6] && (colour != 3'b000), colour};
	endfunction

	// {rom_cs_n, vram_rd_n, vram_wr_n, rom_page, vram_a or zero for rom}
	function automatic logic [22:0] mem_expect(input int addr, input int bank, input int page,
			input bit is_write);
		logic [15:0] a;
		logic [2:0]  sel;
		a = addr[15:0];
		if (a < 16'h4000)
			return {1'b0, 1'b1, 1'b1, page[0], 19'h0};
		if (a < 16'h8000)
			sel = 3'd5;
		else if (a < 16'hC000)
			sel = 3'd2;
		else
			sel = bank[2:0];
		return {1'b1, is_write, !is_write, page[0], 2'b11, sel, a[13:0]};
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic add_entry(input string name, input int op, input int addr, input int data,
			input int line, input int slot, input int exp);
		t_name.push_back(name);
		t_op.push_back(op);
		t_addr.push_back(addr);
		t_data.push_back(data);
		t_line.push_back(line);
		t_slot.push_back(slot);
		t_exp.push_back(exp);
	endtask

	task automatic add_pixel(input string name, input int bank, input int x, input int y);
		add_entry(name, OP_PROBE, 0, 0, y, x + SCREEN_DELAY, int'(expected_pixel(bank, x, y)));
	endtask

	task automatic add_mem(input string name, input int addr, input int bank, input int page,
			input bit is_write);
		add_entry(name, is_write ? OP_MEM_WR : OP_MEM_RD, addr, 0, 0, 0,
			int'(mem_expect(addr, bank, page, is_write)));
	endtask

	task automatic build_table();
		int d;
		add_entry("fe_write_a", OP_FE_WR, 'h00FE, 'h1A, 0, 0, 'h1A >> 3);
		add_entry("border_red", OP_PROBE, 0, 0, 100, 300, 'h2);
		add_entry("fe_write_b", OP_FE_WR, 'h00FE, 'h05, 0, 0, 'h05 >> 3);
		add_entry("border_right", OP_PROBE, 0, 0, 10, 280, 'h5);
		add_entry("border_bottom", OP_PROBE, 0, 0, 200, 100, 'h5);
		add_entry("hblank", OP_PROBE, 0, 0, 100, 350, 0);
		repeat (2) begin
			d = $urandom % 64;   // {tape_in, kd}
			add_entry("fe_read", OP_FE_RD, 'hFFFE, d, 0, 0,
				'h1A0 | (d & 'h1F) | ((d & 'h20) << 1));
		end
		add_pixel("pixel_0_0", 5, 0, 0);
		add_pixel("pixel_13_37", 5, 13, 37);
		add_pixel("pixel_130_100", 5, 130, 100);
		add_pixel("pixel_77_150", 5, 77, 150);
		add_pixel("pixel_255_191", 5, 255, 191);
		add_entry("shadow_on", OP_7FFD_WR, 'h7FFD, 'h0B, 0, 0, 0);   // bank 3, shadow screen
		add_pixel("shadow_40_64", 7, 40, 64);
		add_pixel("shadow_200_8", 7, 200, 8);
		add_mem("read_c000", 'hC123, 3, 0, 0);
		add_mem("read_4000", 'h4567, 3, 0, 0);
		add_mem("read_8000", 'h8001, 3, 0, 0);
		add_mem("read_rom0", 'h0100, 3, 0, 0);
		add_mem("write_c000", 'hC0DE, 3, 0, 1);
		add_entry("lock_on", OP_7FFD_WR, 'h7FFD, 'h36, 0, 0, 0);   // bank 6, rom 1, lock
		add_mem("read_rom1", 'h1234, 6, 1, 0);
		add_mem("read_c000_bank6", 'hC000, 6, 1, 0);
		add_entry("write_locked", OP_7FFD_WR, 'h7FFD, 'h01, 0, 0, 0);
		add_mem("read_still_bank6", 'hFFFF, 6, 1, 0);
		add_pixel("normal_100_120", 5, 100, 120);
	endtask

	task automatic bus_idle();
		cpu_a = 16'h0000;
		cpu_d_in = 8'h00;
		rd_n = 1'b1;
		wr_n = 1'b1;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		m1_n = 1'b1;
		rfsh_n = 1'b1;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk14);
		cpu_a = addr;
		cpu_d_in = data;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		@(negedge clk14);
		bus_idle();
		@(negedge clk14);
	endtask

	task automatic io_read(input logic [15:0] addr, output logic [8:0] seen);
		@(negedge clk14);
		cpu_a = addr;
		iorq_n = 1'b0;
		rd_n = 1'b0;
		@(negedge clk14);   // port_rd one edge later
		seen = {cpu_d_oe, cpu_d_out};
		bus_idle();
		@(negedge clk14);
	endtask

	task automatic mem_access(input logic [15:0] addr, input bit is_write,
			output logic [22:0] seen);
		@(negedge clk14);
		cpu_a = addr;
		mreq_n = 1'b0;
		rd_n = is_write;
		wr_n = !is_write;
		@(negedge clk14);
		seen = {rom_cs_n, vram_rd_n, vram_wr_n, rom_page, rom_cs_n ? vram_a : 19'h0};
		bus_idle();
		@(negedge clk14);
	endtask

	// from the start of the line so every fetch runs with the cpu idle
	task automatic probe(input int line, input int slot, output logic [3:0] seen);
		@(negedge clk14);
		while (!(line_now == line && hc2_now == 0))
			@(negedge clk14);
		while (hc2_now != 2 * slot + 1)
			@(negedge clk14);
		seen = {i, g, r, b};
	endtask

	task automatic frame_timing();
		time t0, t1, t2;
		@(posedge cpu_clk) t0 = $time;   // clk14 / 4
		@(negedge cpu_clk) t1 = $time;
		@(posedge cpu_clk) t2 = $time;
		check("cpu_clk_high", 32'd2, 32'((t1 - t0) / CLK_NS));
		check("cpu_clk_period", 32'd4, 32'((t2 - t0) / CLK_NS));
		@(posedge hsync) t0 = $time;
		@(negedge clk14);
		check("csync_in_hsync", 32'd0, 32'(csync));
		@(negedge hsync) t1 = $time;
		@(negedge clk14);
		check("csync_idle", 32'd1, 32'(csync));
		@(posedge hsync) t2 = $time;
		check("hsync_width", 32'(2 * 33), 32'((t1 - t0) / CLK_NS));
		check("hsync_period", 32'(LINE_CYCLES), 32'((t2 - t0) / CLK_NS));
		@(posedge vsync) t0 = $time;
		@(negedge vsync) t1 = $time;
		@(posedge vsync) t2 = $time;
		check("vsync_width", 32'(8 * LINE_CYCLES), 32'((t1 - t0) / CLK_NS));
		check("vsync_period", 32'(FRAME_CYCLES), 32'((t2 - t0) / CLK_NS));
		@(negedge int_n) t0 = $time;
		@(negedge clk14);
		check("int_line", 32'd239, 32'(line_now));
		@(posedge int_n) t1 = $time;
		@(negedge int_n) t2 = $time;
		check("int_width", 32'(2 * (384 - 316)), 32'((t1 - t0) / CLK_NS));
		check("int_period", 32'(FRAME_CYCLES), 32'((t2 - t0) / CLK_NS));
	endtask

	task automatic run_entry(input int n);
		int          addr, data;
		logic [8:0]  rd_seen;
		logic [22:0] mem_seen;
		logic [3:0]  px_seen;
		addr = t_addr[n];
		data = t_data[n];
		case (t_op[n])
			OP_FE_WR: begin
				io_write(addr[15:0], data[7:0]);
				check(t_name[n], 32'(t_exp[n]), 32'({beeper, tape_out}));
			end
			OP_FE_RD: begin
				{tape_in, kd} = data[5:0];
				io_read(addr[15:0], rd_seen);
				check(t_name[n], 32'(t_exp[n]), 32'(rd_seen));
			end
			OP_7FFD_WR: begin
				io_write(addr[15:0], data[7:0]);
			end
			OP_MEM_RD, OP_MEM_WR: begin
				mem_access(addr[15:0], t_op[n] == OP_MEM_WR, mem_seen);
				check(t_name[n], 32'(t_exp[n]), 32'(mem_seen));
			end
			default: begin
				probe(t_line[n], t_slot[n], px_seen);
				check(t_name[n], 32'(t_exp[n]), 32'(px_seen));   // {i, g, r, b}
			end
		endcase
	endtask

	initial begin
		longint limit;
		wait (table_ready);
		limit = longint'(4 + t_name.size()) * FRAME_CYCLES * CLK_NS;
		#(limit);
		$display("watchdog expired after %0d ns, the run did not finish", limit);
		$display("Test failures found");
		$finish;
	end

	initial begin
		void'($urandom(42694));
		bus_idle();
		kd = 5'b11111;
		tape_in = 1'b0;
		rst_n = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk14);
		@(negedge clk14);
		check("reset_state", 32'h0F00, 32'({int_n, vram_rd_n, vram_wr_n, rom_cs_n, cpu_d_oe,
			hsync, vsync, csync, i, g, r, b}));
		rst_n = 1'b1;
		frame_timing();
		for (int n = 0; n < t_name.size(); n++)
			run_entry(n);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end
		else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire
